// ==== verilog/lc4_pkg.sv ====
`default_nettype none

package lc4_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   // n, z, p from msb down
   typedef logic [2:0]  nzp_t;

   localparam word_t PC_RESET = 16'h8200;
   localparam int    NUM_REGS = 8;

   typedef enum logic [3:0] {
      OPC_BR    = 4'b0000,
      OPC_ARITH = 4'b0001,
      OPC_LOGIC = 4'b0101,
      OPC_LDR   = 4'b0110,
      OPC_STR   = 4'b0111,
      OPC_CONST = 4'b1001
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_NONE,
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_ADDI,
      ALU_CONST,
      ALU_ADDR
   } alu_op_e;

   // code 1 is unused with a single pipe
   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_FLUSH = 2'd2,
      STALL_LOAD  = 2'd3
   } stall_e;

   typedef enum logic [1:0] {
      BYP_REG,
      BYP_M,
      BYP_W
   } byp_e;

   typedef struct packed {
      reg_idx_t rs;
      logic     rs_re;
      reg_idx_t rt;
      logic     rt_re;
      reg_idx_t rd;
      logic     rd_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      alu_op_e  alu_op;
   } ctrl_t;

   localparam ctrl_t CTRL_NOP = '{
      rs: 3'd0, rs_re: 1'b0, rt: 3'd0, rt_re: 1'b0, rd: 3'd0, rd_we: 1'b0,
      nzp_we: 1'b0, is_load: 1'b0, is_store: 1'b0, is_branch: 1'b0, alu_op: ALU_NONE
   };

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  rs_data;
      word_t  rt_data;
      stall_e stall;
   } stage_t;

   typedef struct packed {
      word_t    pc;
      word_t    insn;
      stall_e   stall;
      logic     rd_we;
      reg_idx_t rd;
      word_t    rd_data;
      logic     nzp_we;
      nzp_t     nzp;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;
   } retire_t;

   function automatic nzp_t nzp_of(word_t value);
      return (value == 16'd0) ? 3'b010 : (value[15] ? 3'b100 : 3'b001);
   endfunction

   // empty slot, tagged with the reason it is empty
   function automatic stage_t make_bubble(stall_e kind);
      stage_t s;
      s.pc      = '0;
      s.insn    = '0;
      s.ctrl    = CTRL_NOP;
      s.rs_data = '0;
      s.rt_data = '0;
      s.stall   = kind;
      return s;
   endfunction

endpackage

`default_nettype wire

// ==== verilog/lc4_fetch.sv ====
`default_nettype none

module lc4_fetch (
   input  wire                 gwe,
   input  wire                 i_rst_n,
   input  wire logic           i_stall,
   input  wire logic           i_redirect,
   input  wire lc4_pkg::word_t i_target,
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::word_t      o_pc,
   output lc4_pkg::word_t      o_d_pc,
   output lc4_pkg::word_t      o_d_insn,
   output logic                o_d_valid
);
   import lc4_pkg::*;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_pc      <= PC_RESET;
         o_d_valid <= 1'b0;
      end else if (i_redirect) begin
         // wrong-path fetch is dropped, restart at the target
         o_pc      <= i_target;
         o_d_valid <= 1'b0;
      end else if (!i_stall) begin
         o_pc      <= o_pc + 16'd1;
         o_d_valid <= 1'b1;
      end
   end

   // decode slot contents, held while decode stalls
   always_ff @(posedge gwe) begin
      if (!i_stall) begin
         o_d_pc   <= o_pc;
         o_d_insn <= i_insn;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_decoder.sv ====
`default_nettype none

module lc4_decoder (
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t      o_ctrl
);
   import lc4_pkg::*;

   reg_idx_t   f_rd;
   reg_idx_t   f_rs;
   reg_idx_t   f_rt;
   logic [2:0] f_sub;
   logic       reg_reg_op;

   assign f_rd  = i_insn[11:9];
   assign f_rs  = i_insn[8:6];
   assign f_rt  = i_insn[2:0];
   assign f_sub = i_insn[5:3];

   always_comb begin
      o_ctrl = CTRL_NOP;
      case (opcode_e'(i_insn[15:12]))
         // zero mask never branches, stays a nop
         OPC_BR: o_ctrl.is_branch = (i_insn[11:9] != 3'b000);
         OPC_ARITH: begin
            if (i_insn[5]) begin
               o_ctrl.alu_op = ALU_ADDI;
            end else if (f_sub == 3'b000) begin
               o_ctrl.alu_op = ALU_ADD;
            end else if (f_sub == 3'b010) begin
               o_ctrl.alu_op = ALU_SUB;
            end
         end
         OPC_LOGIC: begin
            if (f_sub == 3'b000) begin
               o_ctrl.alu_op = ALU_AND;
            end else if (f_sub == 3'b010) begin
               o_ctrl.alu_op = ALU_OR;
            end
         end
         OPC_LDR: begin
            o_ctrl.alu_op  = ALU_ADDR;
            o_ctrl.is_load = 1'b1;
         end
         OPC_STR: begin
            o_ctrl.alu_op   = ALU_ADDR;
            o_ctrl.is_store = 1'b1;
         end
         OPC_CONST: o_ctrl.alu_op = ALU_CONST;
         default: o_ctrl = CTRL_NOP;
      endcase

      reg_reg_op = o_ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR};

      // register usage follows from the operation picked above
      if (o_ctrl.alu_op != ALU_NONE) begin
         o_ctrl.rs     = f_rs;
         o_ctrl.rs_re  = (o_ctrl.alu_op != ALU_CONST);
         // store data register sits in the rd field
         o_ctrl.rt     = o_ctrl.is_store ? f_rd : f_rt;
         o_ctrl.rt_re  = reg_reg_op || o_ctrl.is_store;
         o_ctrl.rd     = f_rd;
         o_ctrl.rd_we  = !o_ctrl.is_store;
         o_ctrl.nzp_we = !o_ctrl.is_store;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_regfile.sv ====
`default_nettype none

module lc4_regfile (
   input  wire                    gwe,
   input  wire                    i_rst_n,
   input  wire lc4_pkg::reg_idx_t i_rs,
   input  wire lc4_pkg::reg_idx_t i_rt,
   input  wire lc4_pkg::reg_idx_t i_rd,
   input  wire logic              i_rd_we,
   input  wire lc4_pkg::word_t    i_wdata,
   output lc4_pkg::word_t         o_rs_data,
   output lc4_pkg::word_t         o_rt_data
);
   import lc4_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // write-through, decode sees the value written back this cycle
   assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// ==== verilog/lc4_hazard_ctrl.sv ====
`default_nettype none

module lc4_hazard_ctrl (
   input  wire lc4_pkg::ctrl_t  i_d_ctrl,
   input  wire logic            i_d_valid,
   input  wire lc4_pkg::stage_t i_x,
   input  wire lc4_pkg::ctrl_t  i_m_ctrl,
   input  wire lc4_pkg::ctrl_t  i_w_ctrl,
   input  wire logic            i_redirect,
   output logic                 o_stall_d,
   output logic                 o_flush,
   output lc4_pkg::byp_e        o_rs_sel,
   output lc4_pkg::byp_e        o_rt_sel,
   output lc4_pkg::byp_e        o_st_sel
);
   import lc4_pkg::*;

   ctrl_t x_ctrl;
   logic  load_use;

   // M is younger than W, so it is checked first
   function automatic byp_e pick_src(reg_idx_t r, logic re, ctrl_t m, ctrl_t w);
      if (re && m.rd_we && m.rd == r) begin
         return BYP_M;
      end
      if (re && w.rd_we && w.rd == r) begin
         return BYP_W;
      end
      return BYP_REG;
   endfunction

   assign x_ctrl = i_x.ctrl;

   // load data exists only in W; store data is patched in M instead
   always_comb begin
      load_use = 1'b0;
      if (x_ctrl.is_load && x_ctrl.rd_we) begin
         load_use = (i_d_ctrl.rs_re && i_d_ctrl.rs == x_ctrl.rd) ||
                    (i_d_ctrl.rt_re && i_d_ctrl.rt == x_ctrl.rd && !i_d_ctrl.is_store) ||
                    i_d_ctrl.is_branch;
      end
   end

   assign o_stall_d = i_d_valid && load_use;

   // an empty decode slot also enters execute as a flush bubble
   assign o_flush = i_redirect || !i_d_valid;

   assign o_rs_sel = pick_src(x_ctrl.rs, x_ctrl.rs_re, i_m_ctrl, i_w_ctrl);
   assign o_rt_sel = pick_src(x_ctrl.rt, x_ctrl.rt_re, i_m_ctrl, i_w_ctrl);

   // WM path for a store right behind the load of its data
   assign o_st_sel = (i_m_ctrl.is_store && i_w_ctrl.rd_we && i_w_ctrl.rd == i_m_ctrl.rt) ?
                     BYP_W : BYP_REG;

endmodule

`default_nettype wire

// ==== verilog/lc4_execute.sv ====
`default_nettype none

module lc4_execute (
   input  wire                  gwe,
   input  wire                  i_rst_n,
   input  wire lc4_pkg::stage_t i_x,
   input  wire lc4_pkg::byp_e   i_rs_sel,
   input  wire lc4_pkg::byp_e   i_rt_sel,
   input  wire lc4_pkg::word_t  i_m_result,
   input  wire lc4_pkg::word_t  i_w_result,
   input  wire logic            i_w_nzp_we,
   input  wire logic            i_m_nzp_we,
   output lc4_pkg::stage_t      o_result,
   output logic                 o_redirect,
   output lc4_pkg::word_t       o_target
);
   import lc4_pkg::*;

   word_t rs_val;
   word_t rt_val;
   word_t alu_out;
   word_t imm5;
   word_t imm6;
   word_t imm9;
   nzp_t  nzp_q;
   nzp_t  nzp_cur;

   function automatic word_t bypass(byp_e sel, word_t reg_val, word_t m_val, word_t w_val);
      case (sel)
         BYP_M:   return m_val;
         BYP_W:   return w_val;
         default: return reg_val;
      endcase
   endfunction

   assign imm5 = {{11{i_x.insn[4]}}, i_x.insn[4:0]};
   assign imm6 = {{10{i_x.insn[5]}}, i_x.insn[5:0]};
   assign imm9 = {{7{i_x.insn[8]}}, i_x.insn[8:0]};

   assign rs_val = bypass(i_rs_sel, i_x.rs_data, i_m_result, i_w_result);
   assign rt_val = bypass(i_rt_sel, i_x.rt_data, i_m_result, i_w_result);

   always_comb begin
      case (i_x.ctrl.alu_op)
         ALU_ADD:   alu_out = rs_val + rt_val;
         ALU_SUB:   alu_out = rs_val - rt_val;
         ALU_AND:   alu_out = rs_val & rt_val;
         ALU_OR:    alu_out = rs_val | rt_val;
         ALU_ADDI:  alu_out = rs_val + imm5;
         ALU_CONST: alu_out = imm9;
         // effective address for LDR and STR
         ALU_ADDR:  alu_out = rs_val + imm6;
         default:   alu_out = '0;
      endcase
   end

   // architectural nzp, updated as writers leave W
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         nzp_q <= 3'b000;
      end else if (i_w_nzp_we) begin
         nzp_q <= nzp_of(i_w_result);
      end
   end

   // youngest older nzp writer wins
   assign nzp_cur = i_m_nzp_we ? nzp_of(i_m_result) :
                    i_w_nzp_we ? nzp_of(i_w_result) : nzp_q;

   assign o_target   = i_x.pc + 16'd1 + imm9;
   assign o_redirect = i_x.ctrl.is_branch && |(i_x.insn[11:9] & nzp_cur);

   // alu result travels in rs_data, bypassed store data in rt_data
   always_comb begin
      o_result         = i_x;
      o_result.rs_data = alu_out;
      o_result.rt_data = rt_val;
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_mem_wb.sv ====
`default_nettype none

module lc4_mem_wb (
   input  wire                  gwe,
   input  wire                  i_rst_n,
   input  wire lc4_pkg::stage_t i_m_in,
   input  wire lc4_pkg::byp_e   i_st_sel,
   input  wire lc4_pkg::word_t  i_dmem_rdata,
   output lc4_pkg::word_t       o_dmem_addr,
   output lc4_pkg::word_t       o_dmem_towrite,
   output logic                 o_dmem_we,
   output lc4_pkg::ctrl_t       o_m_ctrl,
   output lc4_pkg::ctrl_t       o_w_ctrl,
   output lc4_pkg::word_t       o_m_result,
   output lc4_pkg::word_t       o_w_result,
   output lc4_pkg::retire_t     o_retire
);
   import lc4_pkg::*;

   stage_t m_q;
   stage_t m_out;
   stage_t w_q;
   word_t  w_load_data;
   word_t  st_data;
   logic   w_mem_op;

   // store data may belong to the load now in W
   assign st_data = (i_st_sel == BYP_W) ? o_w_result : m_q.rt_data;

   always_comb begin
      m_out         = m_q;
      m_out.rt_data = st_data;
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         m_q <= make_bubble(STALL_FLUSH);
         w_q <= make_bubble(STALL_FLUSH);
      end else begin
         m_q <= i_m_in;
         w_q <= m_out;
      end
   end

   always_ff @(posedge gwe) begin
      w_load_data <= i_dmem_rdata;
   end

   assign o_dmem_addr    = m_q.rs_data;
   assign o_dmem_we      = m_q.ctrl.is_store;
   assign o_dmem_towrite = m_q.ctrl.is_store ? st_data : '0;

   assign o_m_ctrl   = m_q.ctrl;
   assign o_m_result = m_q.rs_data;
   assign o_w_ctrl   = w_q.ctrl;
   assign o_w_result = w_q.ctrl.is_load ? w_load_data : w_q.rs_data;

   assign w_mem_op = w_q.ctrl.is_load || w_q.ctrl.is_store;

   always_comb begin
      o_retire.pc        = w_q.pc;
      o_retire.insn      = w_q.insn;
      o_retire.stall     = w_q.stall;
      o_retire.rd_we     = w_q.ctrl.rd_we;
      o_retire.rd        = w_q.ctrl.rd;
      o_retire.rd_data   = o_w_result;
      o_retire.nzp_we    = w_q.ctrl.nzp_we;
      o_retire.nzp       = nzp_of(o_w_result);
      o_retire.dmem_we   = w_q.ctrl.is_store;
      o_retire.dmem_addr = w_mem_op ? w_q.rs_data : '0;
      o_retire.dmem_data = w_q.ctrl.is_store ? w_q.rt_data :
                           (w_q.ctrl.is_load ? w_load_data : '0);
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_pipeline.sv ====
`default_nettype none

module lc4_pipeline (
   input  wire                 gwe,
   input  wire                 i_rst_n,
   output lc4_pkg::word_t      o_cur_pc,
   input  wire lc4_pkg::word_t i_cur_insn,
   output lc4_pkg::word_t      o_dmem_addr,
   input  wire lc4_pkg::word_t i_cur_dmem_data,
   output logic                o_dmem_we,
   output lc4_pkg::word_t      o_dmem_towrite,
   output lc4_pkg::retire_t    o_retire
);
   import lc4_pkg::*;

   word_t  d_pc;
   word_t  d_insn;
   logic   d_valid;
   ctrl_t  d_ctrl;
   word_t  d_rs_data;
   word_t  d_rt_data;
   stage_t x_q;
   stage_t x_result;
   logic   stall_d;
   logic   flush;
   logic   redirect;
   word_t  target;
   byp_e   rs_sel;
   byp_e   rt_sel;
   byp_e   st_sel;
   ctrl_t  m_ctrl;
   ctrl_t  w_ctrl;
   word_t  m_result;
   word_t  w_result;

   lc4_fetch i_fetch (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_stall(stall_d), .i_redirect(redirect),
      .i_target(target), .i_insn(i_cur_insn), .o_pc(o_cur_pc),
      .o_d_pc(d_pc), .o_d_insn(d_insn), .o_d_valid(d_valid)
   );

   lc4_decoder i_decoder (.i_insn(d_insn), .o_ctrl(d_ctrl));

   lc4_regfile i_regfile (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_rs(d_ctrl.rs), .i_rt(d_ctrl.rt),
      .i_rd(w_ctrl.rd), .i_rd_we(w_ctrl.rd_we), .i_wdata(w_result),
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
   );

   lc4_hazard_ctrl i_hazard_ctrl (
      .i_d_ctrl(d_ctrl), .i_d_valid(d_valid), .i_x(x_q), .i_m_ctrl(m_ctrl),
      .i_w_ctrl(w_ctrl), .i_redirect(redirect), .o_stall_d(stall_d), .o_flush(flush),
      .o_rs_sel(rs_sel), .o_rt_sel(rt_sel), .o_st_sel(st_sel)
   );

   // decode to execute; a squashed or held slot enters as a bubble
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         x_q <= make_bubble(STALL_FLUSH);
      end else if (flush) begin
         x_q <= make_bubble(STALL_FLUSH);
      end else if (stall_d) begin
         x_q <= make_bubble(STALL_LOAD);
      end else begin
         x_q.pc      <= d_pc;
         x_q.insn    <= d_insn;
         x_q.ctrl    <= d_ctrl;
         x_q.rs_data <= d_rs_data;
         x_q.rt_data <= d_rt_data;
         x_q.stall   <= STALL_NONE;
      end
   end

   lc4_execute i_execute (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_x(x_q), .i_rs_sel(rs_sel), .i_rt_sel(rt_sel),
      .i_m_result(m_result), .i_w_result(w_result), .i_w_nzp_we(w_ctrl.nzp_we),
      .i_m_nzp_we(m_ctrl.nzp_we), .o_result(x_result), .o_redirect(redirect),
      .o_target(target)
   );

   lc4_mem_wb i_mem_wb (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_m_in(x_result), .i_st_sel(st_sel),
      .i_dmem_rdata(i_cur_dmem_data), .o_dmem_addr(o_dmem_addr),
      .o_dmem_towrite(o_dmem_towrite), .o_dmem_we(o_dmem_we), .o_m_ctrl(m_ctrl),
      .o_w_ctrl(w_ctrl), .o_m_result(m_result), .o_w_result(w_result),
      .o_retire(o_retire)
   );

endmodule

`default_nettype wire

// ==== bench/lc4_pipeline_assertions.sv ====
`default_nettype none

module lc4_pipeline_assertions (
   input wire                   gwe,
   input wire                   i_rst_n,
   input wire logic             i_dmem_we,
   input wire lc4_pkg::word_t   i_cur_pc,
   input wire lc4_pkg::retire_t i_retire
);
   import lc4_pkg::*;

   // no stores while in reset
   assert property (@(posedge gwe) !i_rst_n |-> !i_dmem_we)
      else $error("dmem write during reset");

   // bubbles write nothing
   assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_retire.stall != STALL_NONE |->
         !i_retire.rd_we && !i_retire.nzp_we && !i_retire.dmem_we)
      else $error("stall record carries a write enable");

   assert property (@(posedge gwe) $rose(i_rst_n) |-> i_cur_pc == PC_RESET)
      else $error("first fetch after reset is not the reset pc");

endmodule

bind lc4_pipeline lc4_pipeline_assertions i_assertions (
   .gwe(gwe),
   .i_rst_n(i_rst_n),
   .i_dmem_we(o_dmem_we),
   .i_cur_pc(o_cur_pc),
   .i_retire(o_retire)
);

`default_nettype wire

// ==== bench/tb_lc4_pipeline.sv ====
`default_nettype none

module tb_lc4_pipeline;
   import lc4_pkg::*;

   localparam int PROG_LEN       = 200;
   localparam int PERIOD         = 40;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 100 + RESET_CYCLES;

   logic    gwe;
   logic    i_rst_n;
   word_t   i_cur_insn;
   word_t   i_cur_dmem_data;
   word_t   o_cur_pc;
   word_t   o_dmem_addr;
   word_t   o_dmem_towrite;
   logic    o_dmem_we;
   retire_t o_retire;

   word_t       imem [PROG_LEN];
   word_t       dmem [word_t];
   word_t       model_mem [word_t];
   word_t       model_regs [NUM_REGS];
   nzp_t        model_nzp;
   word_t       model_pc;
   logic [15:0] lfsr;
   int          error_count;
   int          pending_flush;
   logic        pending_load;
   logic        started;
   logic        done;

   lc4_pipeline i_lc4_pipeline (
      .gwe(gwe), .i_rst_n(i_rst_n), .o_cur_pc(o_cur_pc), .i_cur_insn(i_cur_insn),
      .o_dmem_addr(o_dmem_addr), .i_cur_dmem_data(i_cur_dmem_data), .o_dmem_we(o_dmem_we),
      .o_dmem_towrite(o_dmem_towrite), .o_retire(o_retire)
   );

   // fibonacci lfsr with taps 16 14 13 11
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic logic [15:0] take_bits(int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[14:0], lfsr_bit()};
      end
      return r;
   endfunction

   // outside the program the memory reads as BR with a zero mask
   function automatic word_t fetch_word(word_t pc);
      int idx;
      idx = int'(pc) - int'(PC_RESET);
      if (idx >= 0 && idx < PROG_LEN) begin
         return imem[idx];
      end
      return '0;
   endfunction

   function automatic word_t dmem_read(word_t addr);
      return dmem.exists(addr) ? dmem[addr] : '0;
   endfunction

   function automatic word_t model_read(word_t addr);
      return model_mem.exists(addr) ? model_mem[addr] : '0;
   endfunction

   // does insn read register r in a way that waits for load data
   function automatic logic needs_load_data(word_t insn, reg_idx_t r);
      case (insn[15:12])
         4'b0001: return insn[5] ? (insn[8:6] == r) : (insn[8:6] == r || insn[2:0] == r);
         4'b0101: return insn[8:6] == r || insn[2:0] == r;
         4'b0110: return insn[8:6] == r;
         4'b0111: return insn[8:6] == r;
         4'b0000: return insn[11:9] != 3'b000;
         default: return 1'b0;
      endcase
   endfunction

   task automatic check_value(string name, word_t expected, word_t actual);
      if (expected !== actual) begin
         error_count++;
         $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   task automatic build_program();
      logic [15:0] b;
      reg_idx_t    rd;
      reg_idx_t    rs;
      reg_idx_t    rt;
      reg_idx_t    prev_rd;
      logic        prev_load;
      logic        force_st;
      logic        dep;
      int          off;
      prev_rd   = 3'd0;
      prev_load = 1'b0;
      for (int i = 0; i < PROG_LEN; i++) begin
         dep = lfsr_bit();
         b   = take_bits(3);
         rd  = b[2:0];
         b   = dep ? {13'd0, prev_rd} : take_bits(3);
         rs  = b[2:0];
         b   = take_bits(3);
         rt  = b[2:0];
         b   = take_bits(3);
         // store of the register that the load just before it fills
         force_st = prev_load && dep && b[0];
         case (force_st ? 3'd6 : b[2:0])
            3'd0: imem[i] = {4'b0001, rd, rs, 3'b000, rt};
            3'd1: imem[i] = {4'b0001, rd, rs, 3'b010, rt};
            3'd2: imem[i] = {4'b0101, rd, rs, 3'b000, rt};
            3'd3: imem[i] = {4'b0101, rd, rs, 3'b010, rt};
            3'd4: imem[i] = {4'b0001, rd, rs, 1'b1, 5'(take_bits(5))};
            3'd5: imem[i] = {4'b1001, rd, 9'(take_bits(9))};
            3'd6: begin
               if (!force_st && lfsr_bit()) begin
                  imem[i] = {4'b0110, rd, rs, 6'(take_bits(6))};
               end else begin
                  // data register may come from the last writer
                  imem[i] = {4'b0111, dep ? prev_rd : rd, rt, 6'(take_bits(6))};
               end
            end
            default: begin
               off = int'(take_bits(3));
               if (i + 1 + off > PROG_LEN) begin
                  off = 0;
               end
               imem[i] = {4'b0000, 3'(take_bits(3)), 9'(off)};
            end
         endcase
         if (imem[i][15:12] != 4'b0111 && imem[i][15:12] != 4'b0000) begin
            prev_rd = rd;
         end
         prev_load = (imem[i][15:12] == 4'b0110);
      end
   endtask

   task automatic step_model(retire_t r);
      word_t    insn;
      word_t    a;
      word_t    b;
      word_t    val;
      word_t    next_pc;
      logic     we;
      logic     dwe;
      logic     taken;
      word_t    daddr;
      word_t    ddata;
      reg_idx_t rd;
      insn    = fetch_word(model_pc);
      a       = model_regs[insn[8:6]];
      b       = model_regs[insn[2:0]];
      rd      = insn[11:9];
      next_pc = model_pc + 16'd1;
      {we, dwe, taken} = 3'b000;
      val   = '0;
      daddr = '0;
      ddata = '0;
      check_value("retire.pc", model_pc, r.pc);
      check_value("retire.insn", insn, r.insn);
      case (insn[15:12])
         4'b0001: begin
            we = 1'b1;
            if (insn[5]) begin
               val = a + {{11{insn[4]}}, insn[4:0]};
            end else begin
               val = (insn[5:3] == 3'b010) ? a - b : a + b;
            end
         end
         4'b0101: begin
            we  = 1'b1;
            val = (insn[5:3] == 3'b010) ? (a | b) : (a & b);
         end
         4'b0110: begin
            we    = 1'b1;
            daddr = a + {{10{insn[5]}}, insn[5:0]};
            val   = model_read(daddr);
            ddata = val;
         end
         4'b0111: begin
            dwe   = 1'b1;
            daddr = a + {{10{insn[5]}}, insn[5:0]};
            ddata = model_regs[rd];
            model_mem[daddr] = ddata;
         end
         4'b1001: begin
            we  = 1'b1;
            val = {{7{insn[8]}}, insn[8:0]};
         end
         4'b0000: begin
            taken = |(insn[11:9] & model_nzp);
            if (taken) begin
               next_pc = model_pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
            end
         end
         default: ;
      endcase
      check_value("retire.rd_we", 16'(we), 16'(r.rd_we));
      check_value("retire.nzp_we", 16'(we), 16'(r.nzp_we));
      if (we) begin
         model_regs[rd] = val;
         model_nzp = (val == 16'd0) ? 3'b010 : (val[15] ? 3'b100 : 3'b001);
         check_value("retire.rd", 16'(rd), 16'(r.rd));
         check_value("retire.rd_data", val, r.rd_data);
         check_value("retire.nzp", 16'(model_nzp), 16'(r.nzp));
      end
      check_value("retire.dmem_we", 16'(dwe), 16'(r.dmem_we));
      check_value("retire.dmem_addr", daddr, r.dmem_addr);
      check_value("retire.dmem_data", ddata, r.dmem_data);
      pending_load = (insn[15:12] == 4'b0110) && needs_load_data(fetch_word(next_pc), rd);
      pending_flush = taken ? 2 : 0;
      model_pc = next_pc;
   endtask

   initial begin
      gwe = 1'b0;
      forever #(PERIOD / 2) gwe = ~gwe;
   end

   // stores land at the rising edge
   always @(posedge gwe) begin
      if (i_rst_n && o_dmem_we) begin
         dmem[o_dmem_addr] = o_dmem_towrite;
      end
   end

   // retire records are read mid-cycle before new inputs go out
   always @(negedge gwe) begin
      if (i_rst_n && !done && (started || o_retire.stall == STALL_NONE)) begin
         started = 1'b1;
         if (pending_flush > 0) begin
            check_value("retire.stall", 16'(STALL_FLUSH), 16'(o_retire.stall));
            pending_flush--;
         end else if (pending_load) begin
            check_value("retire.stall", 16'(STALL_LOAD), 16'(o_retire.stall));
            pending_load = 1'b0;
         end else begin
            check_value("retire.stall", 16'(STALL_NONE), 16'(o_retire.stall));
            step_model(o_retire);
            if (model_pc >= PC_RESET + 16'(PROG_LEN)) begin
               done = 1'b1;
            end
         end
      end
      i_cur_insn      = fetch_word(o_cur_pc);
      i_cur_dmem_data = dmem_read(o_dmem_addr);
   end

   initial begin
      i_rst_n         = 1'b0;
      i_cur_insn      = '0;
      i_cur_dmem_data = '0;
      lfsr            = 16'd57;
      error_count     = 0;
      pending_flush   = 0;
      pending_load    = 1'b0;
      started         = 1'b0;
      done            = 1'b0;
      model_pc        = PC_RESET;
      model_nzp       = 3'b000;
      for (int i = 0; i < NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      build_program();
      repeat (RESET_CYCLES) @(negedge gwe);
      i_rst_n = 1'b1;
      wait (done);
      if (error_count == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         $display("TB FAILED");
         $fatal(1);
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge gwe);
      $display("timeout: program did not finish retiring in time");
      $display("TB FAILED");
      $fatal(1);
   end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/lc4_pkg.sv
verilog/lc4_fetch.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_hazard_ctrl.sv
verilog/lc4_execute.sv
verilog/lc4_mem_wb.sv
verilog/lc4_pipeline.sv
bench/lc4_pipeline_assertions.sv
bench/tb_lc4_pipeline.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_lc4_pipeline
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
